// ==== bottom.f ====
rtl/bottom_pkg.sv
rtl/reg_file.sv
rtl/pointer_regs.sv
rtl/addr_unit.sv
rtl/irq_logic.sv
rtl/bottom.sv
bench/bottom_tb.sv

// ==== Bender.yml ====
package:
  name: bottom

sources:
  - rtl/bottom_pkg.sv
  - rtl/reg_file.sv
  - rtl/pointer_regs.sv
  - rtl/addr_unit.sv
  - rtl/irq_logic.sv
  - rtl/bottom.sv
  - target: test
    files:
      - bench/bottom_tb.sv

// ==== bench/bottom_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module bottom_tb;

	// One cycle of decoder activity and what the DUT should show during it
	typedef struct packed {
		bottom_pkg::bottom_cmd_t cmd;
		bottom_pkg::byte_t data_in;
		bottom_pkg::irq_vec_t irq_trig;
		logic ime;
		bottom_pkg::addr_t exp_addr;
		bottom_pkg::byte_t exp_data;
		bottom_pkg::irq_vec_t exp_ack;
		logic exp_pend;
		logic [3:0] chk;		// {pend, ack, data, addr}
	} row_t;

	logic clk;
	logic rst_n;
	bottom_pkg::bottom_cmd_t cmd;
	bottom_pkg::byte_t data_in;
	bottom_pkg::irq_vec_t irq_trig;
	logic ime;
	bottom_pkg::addr_t addr;
	bottom_pkg::byte_t data_out;
	logic irq_pending;
	bottom_pkg::irq_vec_t irq_ack;

	row_t rows[$];
	row_t cur;
	bottom_pkg::byte_t b_val;
	bottom_pkg::byte_t c_val;
	bottom_pkg::byte_t ie_val;
	bottom_pkg::bottom_cmd_t idle, pc_inc, sp_get, dispatch;
	bottom_pkg::bottom_cmd_t ld_b, ld_c, ld_h, ld_l;
	bottom_pkg::bottom_cmd_t bc_rd_b, bc_rd_c, de_inc;
	bottom_pkg::bottom_cmd_t hl_dec, hl_get, hl_wr, hl_rd;

	bottom i_dut (
		.clk(clk),
		.rst_n(rst_n),
		.cmd(cmd),
		.data_in(data_in),
		.irq_trig(irq_trig),
		.ime(ime),
		.addr(addr),
		.data_out(data_out),
		.irq_pending(irq_pending),
		.irq_ack(irq_ack)
	);

	always #10 clk = ~clk;		// 20 ns period

	task automatic stop_run();
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic check_addr(input bottom_pkg::addr_t exp, input bottom_pkg::addr_t act,
			input int row);
		if (act !== exp) begin
			$display("Fail addr in row %0d: expected %h, got %h", row, exp, act);
			stop_run();
		end
	endtask

	task automatic check_byte(input bottom_pkg::byte_t exp, input bottom_pkg::byte_t act,
			input int row);
		if (act !== exp) begin
			$display("Fail data_out in row %0d: expected %h, got %h", row, exp, act);
			stop_run();
		end
	endtask

	task automatic check_ack(input bottom_pkg::irq_vec_t exp, input bottom_pkg::irq_vec_t act,
			input int row);
		if (act !== exp) begin
			$display("Fail irq_ack in row %0d: expected %h, got %h", row, exp, act);
			stop_run();
		end
	endtask

	task automatic check_pending(input logic exp, input logic act, input int row);
		if (act !== exp) begin
			$display("Fail irq_pending in row %0d: expected %h, got %h", row, exp, act);
			stop_run();
		end
	endtask

	task automatic build_cmds();
		idle = '0;
		idle.addr_pair = bottom_pkg::PAIR_PC;		// Park on PC, nothing else
		pc_inc = idle;
		pc_inc.idu_op = bottom_pkg::IDU_INC;
		pc_inc.idu_wb = 1'b1;
		sp_get = idle;
		sp_get.addr_pair = bottom_pkg::PAIR_SP;
		dispatch = idle;
		dispatch.irq_dispatch = 1'b1;
		ld_b = idle;
		ld_b.load_reg = bottom_pkg::REG_B;
		ld_c = idle;
		ld_c.load_reg = bottom_pkg::REG_C;
		ld_h = idle;
		ld_h.load_reg = bottom_pkg::REG_H;
		ld_l = idle;
		ld_l.load_reg = bottom_pkg::REG_L;
		bc_rd_c = idle;
		bc_rd_c.addr_pair = bottom_pkg::PAIR_BC;
		bc_rd_c.read_reg = bottom_pkg::REG_C;
		bc_rd_b = bc_rd_c;
		bc_rd_b.read_reg = bottom_pkg::REG_B;
		bc_rd_b.rd = 1'b1;
		de_inc = idle;
		de_inc.addr_pair = bottom_pkg::PAIR_DE;
		de_inc.idu_op = bottom_pkg::IDU_INC;
		hl_get = idle;
		hl_get.addr_pair = bottom_pkg::PAIR_HL;
		hl_dec = hl_get;
		hl_dec.idu_op = bottom_pkg::IDU_DEC;
		hl_dec.idu_wb = 1'b1;
		hl_wr = hl_get;
		hl_wr.wr = 1'b1;
		hl_rd = hl_get;
		hl_rd.rd = 1'b1;
	endtask

	task automatic add_row(input bottom_pkg::bottom_cmd_t c, input bottom_pkg::byte_t d,
			input bottom_pkg::irq_vec_t trig, input logic en, input bottom_pkg::addr_t ea,
			input bottom_pkg::byte_t ed, input bottom_pkg::irq_vec_t eack, input logic ep,
			input logic [3:0] chk);
		rows.push_back('{c, d, trig, en, ea, ed, eack, ep, chk});
	endtask

	task automatic build_table();
		add_row(pc_inc, 8'h00, 8'h00, 1'b0, 16'h0000, 8'h00, 8'h00, 1'b0, 4'b0001);
		add_row(pc_inc, 8'h00, 8'h00, 1'b0, 16'h0001, 8'h00, 8'h00, 1'b0, 4'b0001);
		add_row(pc_inc, 8'h00, 8'h00, 1'b0, 16'h0002, 8'h00, 8'h00, 1'b0, 4'b0001);
		add_row(sp_get, 8'h00, 8'h00, 1'b0, 16'hFFFE, 8'h00, 8'h00, 1'b0, 4'b0001);
		add_row(ld_b, b_val, 8'h00, 1'b0, 16'h0000, 8'h00, 8'h00, 1'b0, 4'b0000);
		add_row(ld_c, c_val, 8'h00, 1'b0, 16'h0000, 8'h00, 8'h00, 1'b0, 4'b0000);
		add_row(bc_rd_c, 8'h00, 8'h00, 1'b0, {b_val, c_val}, c_val, 8'h00, 1'b0, 4'b0011);
		add_row(ld_h, 8'h00, 8'h00, 1'b0, 16'h0000, 8'h00, 8'h00, 1'b0, 4'b0000);
		add_row(ld_l, 8'h00, 8'h00, 1'b0, 16'h0000, 8'h00, 8'h00, 1'b0, 4'b0000);
		add_row(hl_dec, 8'h00, 8'h00, 1'b0, 16'h0000, 8'h00, 8'h00, 1'b0, 4'b0001);
		add_row(hl_get, 8'h00, 8'h00, 1'b0, 16'hFFFF, 8'h00, 8'h00, 1'b0, 4'b0001);
		add_row(de_inc, 8'h00, 8'h00, 1'b0, 16'h0000, 8'h00, 8'h00, 1'b0, 4'b0001);
		add_row(de_inc, 8'h00, 8'h00, 1'b0, 16'h0000, 8'h00, 8'h00, 1'b0, 4'b0001);
		add_row(ld_h, 8'hFF, 8'h00, 1'b0, 16'h0000, 8'h00, 8'h00, 1'b0, 4'b0000);
		add_row(ld_l, 8'hFF, 8'h00, 1'b0, 16'h0000, 8'h00, 8'h00, 1'b0, 4'b0000);
		add_row(hl_wr, ie_val, 8'h00, 1'b0, 16'hFFFF, 8'h00, 8'h00, 1'b0, 4'b0001);
		add_row(hl_rd, 8'h00, 8'h00, 1'b0, 16'hFFFF, ie_val, 8'h00, 1'b0, 4'b0010);
		add_row(bc_rd_b, 8'h00, 8'h00, 1'b0, 16'h0000, b_val, 8'h00, 1'b0, 4'b0010);
		add_row(hl_wr, 8'hFF, 8'h00, 1'b0, 16'h0000, 8'h00, 8'h00, 1'b0, 4'b0000);
		add_row(idle, 8'h00, 8'h14, 1'b0, 16'h0000, 8'h00, 8'h00, 1'b0, 4'b0000);
		add_row(dispatch, 8'h00, 8'h00, 1'b1, 16'h0000, 8'h00, 8'h04, 1'b1, 4'b1100);
		add_row(idle, 8'h00, 8'h00, 1'b0, 16'h0050, 8'h00, 8'h00, 1'b0, 4'b0001);
		add_row(dispatch, 8'h00, 8'h00, 1'b1, 16'h0000, 8'h00, 8'h10, 1'b1, 4'b1100);
		add_row(idle, 8'h00, 8'h00, 1'b0, 16'h0060, 8'h00, 8'h00, 1'b0, 4'b0001);
		add_row(dispatch, 8'h00, 8'h00, 1'b1, 16'h0000, 8'h00, 8'h00, 1'b0, 4'b1100);
		add_row(idle, 8'h00, 8'h01, 1'b0, 16'h0000, 8'h00, 8'h00, 1'b0, 4'b0000);
		add_row(dispatch, 8'h00, 8'h00, 1'b0, 16'h0000, 8'h00, 8'h00, 1'b1, 4'b1100);
		add_row(idle, 8'h00, 8'h00, 1'b0, 16'h0060, 8'h00, 8'h00, 1'b0, 4'b0001);
		add_row(hl_wr, 8'hFE, 8'h00, 1'b0, 16'h0000, 8'h00, 8'h00, 1'b0, 4'b0000);
		add_row(dispatch, 8'h00, 8'h00, 1'b1, 16'h0000, 8'h00, 8'h00, 1'b0, 4'b1100);
		add_row(idle, 8'h00, 8'h00, 1'b0, 16'h0060, 8'h00, 8'h00, 1'b0, 4'b0001);
	endtask

	task automatic release_reset();
		int n;
		logic seen;
		n = 0;
		seen = 1'b0;
		@(negedge clk);
		rst_n = 1'b1;
		// cmd is all zero, so addr shows BC
		while (!seen && n < 4) begin
			@(negedge clk);
			seen = (addr === 16'h0000) && (irq_pending === 1'b0) && (irq_ack === 8'h00);
			n++;
		end
		if (!seen) begin
			$display("DUT did not show its reset state within 4 clock cycles");
			stop_run();
		end
	endtask

	initial begin
		clk = 1'b0;
		rst_n = 1'b0;
		cmd = '0;
		data_in = '0;
		irq_trig = '0;
		ime = 1'b0;
		void'($urandom(48723));
		b_val = bottom_pkg::byte_t'($urandom) & 8'h7F;		// Keeps BC away from FFFF
		c_val = bottom_pkg::byte_t'($urandom);
		ie_val = bottom_pkg::byte_t'($urandom);
		build_cmds();
		build_table();
		repeat (16) @(posedge clk);
		release_reset();
		for (int i = 0; i < rows.size(); i++) begin
			@(negedge clk);
			cur = rows[i];
			cmd = cur.cmd;
			data_in = cur.data_in;
			irq_trig = cur.irq_trig;
			ime = cur.ime;
			#5;		// Mid low phase, outputs settled
			if (cur.chk[0])
				check_addr(cur.exp_addr, addr, i);
			if (cur.chk[1])
				check_byte(cur.exp_data, data_out, i);
			if (cur.chk[2])
				check_ack(cur.exp_ack, irq_ack, i);
			if (cur.chk[3])
				check_pending(cur.exp_pend, irq_pending, i);
		end
		@(negedge clk);
		cmd = '0;
		irq_trig = '0;
		ime = 1'b0;
		$display("Simulation passed");
		$finish;
	end

	initial begin
		#20000;
		$display("Timeout: the run did not reach its end in time");
		stop_run();
	end

endmodule

`default_nettype wire

// ==== rtl/bottom.sv ====
`timescale 1ns/1ns
`default_nettype none

module bottom (
	input wire logic clk,
	input wire logic rst_n,
	input wire bottom_pkg::bottom_cmd_t cmd,
	input wire bottom_pkg::byte_t data_in,
	input wire bottom_pkg::irq_vec_t irq_trig,
	input wire logic ime,
	output bottom_pkg::addr_t addr,
	output bottom_pkg::byte_t data_out,
	output logic irq_pending,
	output bottom_pkg::irq_vec_t irq_ack
);

	bottom_pkg::pairs_t pairs;
	bottom_pkg::byte_t rd_byte;
	bottom_pkg::addr_t sp;
	bottom_pkg::addr_t pc;
	bottom_pkg::addr_t idu_result;
	logic ie_hit;
	bottom_pkg::byte_t ie_q;
	bottom_pkg::byte_t irq_vector;
	logic irq_take;

	reg_file i_reg_file (
		.clk(clk),
		.rst_n(rst_n),
		.cmd(cmd),
		.data_in(data_in),
		.idu_result(idu_result),
		.pairs(pairs),
		.rd_byte(rd_byte)
	);

	pointer_regs i_pointer_regs (
		.clk(clk),
		.rst_n(rst_n),
		.cmd(cmd),
		.data_in(data_in),
		.idu_result(idu_result),
		.irq_vector(irq_vector),
		.irq_take(irq_take),
		.sp(sp),
		.pc(pc)
	);

	addr_unit i_addr_unit (
		.cmd(cmd),
		.pairs(pairs),
		.sp(sp),
		.pc(pc),
		.addr(addr),
		.idu_result(idu_result)
	);

	irq_logic i_irq_logic (
		.clk(clk),
		.rst_n(rst_n),
		.cmd(cmd),
		.addr(addr),
		.data_in(data_in),
		.irq_trig(irq_trig),
		.ime(ime),
		.ie_hit(ie_hit),
		.ie_q(ie_q),
		.irq_pending(irq_pending),
		.irq_ack(irq_ack),
		.irq_vector(irq_vector),
		.irq_take(irq_take)
	);

	assign data_out = (cmd.rd && ie_hit) ? ie_q : rd_byte;		// IE read at FFFF

endmodule

`default_nettype wire

// ==== rtl/irq_logic.sv ====
`timescale 1ns/1ns
`default_nettype none

module irq_logic (
	input wire logic clk,
	input wire logic rst_n,
	input wire bottom_pkg::bottom_cmd_t cmd,
	input wire bottom_pkg::addr_t addr,
	input wire bottom_pkg::byte_t data_in,
	input wire bottom_pkg::irq_vec_t irq_trig,
	input wire logic ime,
	output logic ie_hit,
	output bottom_pkg::byte_t ie_q,
	output logic irq_pending,
	output bottom_pkg::irq_vec_t irq_ack,
	output bottom_pkg::byte_t irq_vector,
	output logic irq_take
);

	bottom_pkg::irq_vec_t if_q;		// Latched requests
	bottom_pkg::irq_vec_t active;
	bottom_pkg::irq_vec_t first;		// One-hot winner
	bottom_pkg::irq_idx_t first_idx;

	assign ie_hit = (addr == bottom_pkg::IE_ADDR);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ie_q <= '0;
		end else if (cmd.wr && ie_hit) begin
			ie_q <= data_in;
		end
	end

	// New triggers set, the taken source clears
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			if_q <= '0;
		end else begin
			if_q <= (if_q & ~irq_ack) | irq_trig;
		end
	end

	assign active = if_q & ie_q;
	assign irq_pending = |active;
	assign irq_take = cmd.irq_dispatch & ime & irq_pending;

	// Scan from the top so the lowest index is written last
	always_comb begin
		first = '0;
		first_idx = '0;
		for (int i = bottom_pkg::IRQ_N - 1; i >= 0; i--) begin
			if (active[i]) begin
				first = bottom_pkg::irq_vec_t'(1) << i;
				first_idx = bottom_pkg::irq_idx_t'(i);
			end
		end
	end

	assign irq_ack = irq_take ? first : '0;

	// 40h, 48h, 50h ... one slot per source
	assign irq_vector = bottom_pkg::IRQ_VEC_BASE
		+ bottom_pkg::byte_t'(first_idx) * bottom_pkg::IRQ_VEC_STEP;

endmodule

`default_nettype wire

// ==== rtl/addr_unit.sv ====
`timescale 1ns/1ns
`default_nettype none

module addr_unit (
	input wire bottom_pkg::bottom_cmd_t cmd,
	input wire bottom_pkg::pairs_t pairs,
	input wire bottom_pkg::addr_t sp,
	input wire bottom_pkg::addr_t pc,
	output bottom_pkg::addr_t addr,
	output bottom_pkg::addr_t idu_result
);

	logic dec;
	logic carry;		// Ripples up one bit at a time

	always_comb begin
		case (cmd.addr_pair)
			bottom_pkg::PAIR_BC: addr = pairs.bc;
			bottom_pkg::PAIR_DE: addr = pairs.de;
			bottom_pkg::PAIR_HL: addr = pairs.hl;
			bottom_pkg::PAIR_SP: addr = sp;
			default: addr = pc;
		endcase
	end

	// Increment propagates through ones, decrement through zeros
	always_comb begin
		dec = (cmd.idu_op == bottom_pkg::IDU_DEC);
		carry = dec || (cmd.idu_op == bottom_pkg::IDU_INC);
		for (int i = 0; i < bottom_pkg::ADDR_W; i++) begin
			idu_result[i] = addr[i] ^ carry;
			carry = carry & (dec ? ~addr[i] : addr[i]);
		end
	end

endmodule

`default_nettype wire

// ==== rtl/pointer_regs.sv ====
`timescale 1ns/1ns
`default_nettype none

module pointer_regs (
	input wire logic clk,
	input wire logic rst_n,
	input wire bottom_pkg::bottom_cmd_t cmd,
	input wire bottom_pkg::byte_t data_in,
	input wire bottom_pkg::addr_t idu_result,
	input wire bottom_pkg::byte_t irq_vector,
	input wire logic irq_take,
	output bottom_pkg::addr_t sp,
	output bottom_pkg::addr_t pc
);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			sp <= bottom_pkg::SP_RESET;
			pc <= bottom_pkg::PC_RESET;
		end else begin
			if (cmd.idu_wb && cmd.addr_pair == bottom_pkg::PAIR_SP) begin
				sp <= idu_result;
			end
			if (cmd.idu_wb && cmd.addr_pair == bottom_pkg::PAIR_PC) begin
				pc <= idu_result;
			end
			case (cmd.load_reg)
				bottom_pkg::REG_SPL: sp[7:0] <= data_in;
				bottom_pkg::REG_SPH: sp[15:8] <= data_in;
				bottom_pkg::REG_PCL: pc[7:0] <= data_in;
				bottom_pkg::REG_PCH: pc[15:8] <= data_in;
				default: ;
			endcase
			// Interrupt entry jumps to page zero
			if (irq_take) begin
				pc <= {8'h00, irq_vector};
			end
		end
	end

endmodule

`default_nettype wire

// ==== rtl/reg_file.sv ====
`timescale 1ns/1ns
`default_nettype none

module reg_file (
	input wire logic clk,
	input wire logic rst_n,
	input wire bottom_pkg::bottom_cmd_t cmd,
	input wire bottom_pkg::byte_t data_in,
	input wire bottom_pkg::addr_t idu_result,
	output bottom_pkg::pairs_t pairs,
	output bottom_pkg::byte_t rd_byte
);

	bottom_pkg::byte_t a_q;
	bottom_pkg::byte_t b_q;
	bottom_pkg::byte_t c_q;
	bottom_pkg::byte_t d_q;
	bottom_pkg::byte_t e_q;
	bottom_pkg::byte_t h_q;
	bottom_pkg::byte_t l_q;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			a_q <= '0;
			b_q <= '0;
			c_q <= '0;
			d_q <= '0;
			e_q <= '0;
			h_q <= '0;
			l_q <= '0;
		end else begin
			if (cmd.idu_wb) begin
				case (cmd.addr_pair)
					bottom_pkg::PAIR_BC: {b_q, c_q} <= idu_result;
					bottom_pkg::PAIR_DE: {d_q, e_q} <= idu_result;
					bottom_pkg::PAIR_HL: {h_q, l_q} <= idu_result;
					default: ;		// SP and PC live elsewhere
				endcase
			end
			// Later assignment, so a byte load beats the write-back
			case (cmd.load_reg)
				bottom_pkg::REG_A: a_q <= data_in;
				bottom_pkg::REG_B: b_q <= data_in;
				bottom_pkg::REG_C: c_q <= data_in;
				bottom_pkg::REG_D: d_q <= data_in;
				bottom_pkg::REG_E: e_q <= data_in;
				bottom_pkg::REG_H: h_q <= data_in;
				bottom_pkg::REG_L: l_q <= data_in;
				default: ;
			endcase
		end
	end

	always_comb begin
		pairs.bc = {b_q, c_q};		// High byte first
		pairs.de = {d_q, e_q};
		pairs.hl = {h_q, l_q};
	end

	always_comb begin
		case (cmd.read_reg)
			bottom_pkg::REG_A: rd_byte = a_q;
			bottom_pkg::REG_B: rd_byte = b_q;
			bottom_pkg::REG_C: rd_byte = c_q;
			bottom_pkg::REG_D: rd_byte = d_q;
			bottom_pkg::REG_E: rd_byte = e_q;
			bottom_pkg::REG_H: rd_byte = h_q;
			bottom_pkg::REG_L: rd_byte = l_q;
			default: rd_byte = '0;		// Not held here
		endcase
	end

endmodule

`default_nettype wire

// ==== rtl/bottom_pkg.sv ====
`default_nettype none

package bottom_pkg;

	localparam int BYTE_W = 8;
	localparam int ADDR_W = 16;
	localparam int IRQ_N = 8;
	localparam int IRQ_IDX_W = $clog2(IRQ_N);

	typedef logic [BYTE_W-1:0] byte_t;
	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [IRQ_N-1:0] irq_vec_t;		// Bit 0 wins
	typedef logic [IRQ_IDX_W-1:0] irq_idx_t;

	// Byte targets for loads from the data bus and for read-out
	typedef enum logic [3:0] {
		REG_NONE, REG_A, REG_B, REG_C, REG_D, REG_E, REG_H, REG_L,
		REG_SPL, REG_SPH, REG_PCL, REG_PCH
	} reg8_t;

	typedef enum logic [2:0] {
		PAIR_BC, PAIR_DE, PAIR_HL, PAIR_SP, PAIR_PC
	} pair_t;

	typedef enum logic [1:0] {
		IDU_NONE, IDU_INC, IDU_DEC
	} idu_op_t;

	typedef struct packed {
		addr_t bc;
		addr_t de;
		addr_t hl;
	} pairs_t;

	// One decoder command per cycle
	typedef struct packed {
		pair_t addr_pair;
		idu_op_t idu_op;
		logic idu_wb;		// Result back to addressed pair
		reg8_t load_reg;		// Loaded from data_in
		reg8_t read_reg;		// Driven on data_out
		logic rd;
		logic wr;
		logic irq_dispatch;
	} bottom_cmd_t;

	localparam addr_t IE_ADDR = 16'hFFFF;
	localparam byte_t IRQ_VEC_BASE = 8'h40;
	localparam byte_t IRQ_VEC_STEP = 8'h08;
	localparam addr_t SP_RESET = 16'hFFFE;
	localparam addr_t PC_RESET = 16'h0000;

endpackage

`default_nettype wire
